// File: logic/scb_pkg.sv
//------------------------------
// slow control board monitor readout
// widths, frame opcodes, channel tables, frame union
//------------------------------
package scb_pkg;

	localparam int READING_W = 14;
	localparam int CHANNELS = 20;
	localparam int CHAN_W = 5;
	localparam int MUX_W = 8;
	localparam int OPCODE_W = 3;

	localparam logic [OPCODE_W-1:0] OP_ADC_MUX = 3'b110;
	localparam logic [OPCODE_W-1:0] OP_ADC_SPI = 3'b100;

	localparam logic [CHAN_W-1:0] MUX_FRAME_BITS = 5'd11;
	localparam logic [CHAN_W-1:0] ADC_FRAME_BITS = 5'd17;
	localparam logic [CHAN_W-1:0] CONV_AFTER_BIT = 5'd3; // pause point in an adc frame

	// one 17 bit shift word, MSB goes out first
	typedef union packed {
		struct packed {
			logic [OPCODE_W-1:0] opcode;
			logic [MUX_W-1:0] code;
			logic [ADC_FRAME_BITS-OPCODE_W-MUX_W-1:0] pad; // never shifted
		} mux;
		struct packed {
			logic [OPCODE_W-1:0] opcode;
			logic [ADC_FRAME_BITS-OPCODE_W-1:0] cfg;
		} adc;
	} scb_frame_u;

	function automatic logic [MUX_W-1:0] chan_mux_code(input logic [CHAN_W-1:0] idx);
		case (idx)
			5'd0: return 8'h00; // hv monitor and anode current pairs
			5'd1: return 8'h01;
			5'd2: return 8'h02;
			5'd3: return 8'h03;
			5'd4: return 8'h04;
			5'd5: return 8'h05;
			5'd6: return 8'h06;
			5'd7: return 8'h07;
			5'd8: return 8'h08;
			5'd9: return 8'h09;
			5'd10: return 8'h0a;
			5'd11: return 8'h0b;
			5'd12: return 8'h0d; // temperature
			5'd13: return 8'h0e;
			5'd14: return 8'h0f;
			5'd15: return 8'h1c; // supply rails
			5'd16: return 8'h5c;
			5'd17: return 8'h7c;
			default: return 8'h00; // 18, 19 use adc inputs directly
		endcase
	endfunction

	function automatic logic [ADC_FRAME_BITS-OPCODE_W-1:0] chan_adc_cfg(
		input logic [CHAN_W-1:0] idx
	);
		case (idx)
			5'd18: return 14'b1_111_010_1_011_00_1; // pmt current
			5'd19: return 14'b1_111_011_0_111_00_0; // 1.5V reference
			default: return 14'b1_110_111_1_011_00_1;
		endcase
	endfunction

endpackage

// File: logic/scb_serial_shifter.sv
//------------------------------
// serial bit engine for mdi / msk / mdo
// four phase bit timing, pause for conversion
//------------------------------
`timescale 1ns/10ps

module scb_serial_shifter (
	input  logic clk,
	input  logic rst,
	input  logic frame_load,
	input  scb_pkg::scb_frame_u frame,
	input  logic [scb_pkg::CHAN_W-1:0] frame_bits,
	input  logic mex_strobe,
	input  logic resume,
	input  logic mdo,
	output logic mdi,
	output logic msk,
	output logic mex_bit,
	output logic pause,
	output logic frame_done,
	output logic [scb_pkg::READING_W-1:0] shifted_in
);
	import scb_pkg::*;

	localparam int FW = $bits(scb_frame_u);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_SHIFT = 2'd1;
	localparam logic [1:0] S_PAUSE = 2'd2;

	logic [1:0] state;
	logic [1:0] phase;
	logic [CHAN_W-1:0] bit_cnt;
	logic [CHAN_W-1:0] bit_nxt;
	logic [FW-1:0] sr;

	assign bit_nxt = bit_cnt + 1'b1;
	assign pause = (state == S_PAUSE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			phase <= 2'd0;
			bit_cnt <= '0;
			mdi <= 1'b0;
			msk <= 1'b0;
			mex_bit <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (frame_load) begin
						state <= S_SHIFT;
						phase <= 2'd0;
						bit_cnt <= '0;
					end
				end
				S_SHIFT: begin
					phase <= phase + 2'd1;
					case (phase)
						2'd0: mdi <= sr[FW-1];
						2'd1: begin
							msk <= 1'b1;
							if (mex_strobe)
								mex_bit <= 1'b0;
						end
						2'd2: ; // mdo sampled below
						default: begin
							msk <= 1'b0;
							bit_cnt <= bit_nxt;
							if (bit_nxt == frame_bits) begin
								state <= S_IDLE;
								frame_done <= 1'b1;
								mdi <= 1'b0;
								mex_bit <= 1'b0;
							end else begin
								mex_bit <= mex_strobe;
								if (!mex_strobe && bit_nxt == CONV_AFTER_BIT)
									state <= S_PAUSE;
							end
						end
					endcase
				end
				S_PAUSE: begin
					if (resume)
						state <= S_SHIFT; // phase already back at 0
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && frame_load)
			sr <= frame;
		else if (state == S_SHIFT && phase == 2'd3)
			sr <= {sr[FW-2:0], 1'b0};
		if (state == S_SHIFT && phase == 2'd2)
			shifted_in <= {shifted_in[READING_W-2:0], mdo};
	end

endmodule

// File: logic/scb_adc_sequencer.sv
//------------------------------
// per channel adc sequence
// mux frame, settle wait, repeated adc frames with conversion pulse
//------------------------------
`timescale 1ns/10ps

module scb_adc_sequencer #(
	parameter int MUX_SETTLE_CYCLES = 130000,
	parameter int CONV_PULSE_CYCLES = 230,
	parameter int ADC_REPEATS = 3
) (
	input  logic clk,
	input  logic rst,
	input  logic chan_start,
	input  logic [scb_pkg::CHAN_W-1:0] chan_idx,
	input  logic mdo,
	output logic chan_done,
	output logic [scb_pkg::READING_W-1:0] chan_reading,
	output logic mcs_n,
	output logic mdi,
	output logic msk,
	output logic mex
);
	import scb_pkg::*;

	localparam int CONV_LOW = 10; // mex low before and after the pulse
	localparam int CONV_LEN = CONV_PULSE_CYCLES + 2 * CONV_LOW;
	localparam int CNT_MAX = (MUX_SETTLE_CYCLES > CONV_LEN) ? MUX_SETTLE_CYCLES : CONV_LEN;
	localparam int CNT_W = $clog2(CNT_MAX + 1);
	localparam int REP_W = $clog2(ADC_REPEATS + 1);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_MUX = 3'd1;
	localparam logic [2:0] S_SETTLE = 3'd2;
	localparam logic [2:0] S_ADC = 3'd3;
	localparam logic [2:0] S_CONV = 3'd4;
	localparam logic [2:0] S_RELOAD = 3'd5;

	logic [2:0] state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_nxt;
	logic [REP_W-1:0] rep;
	logic last_rep;
	logic mex_strobe;
	logic mex_conv;
	logic mex_bit;
	logic frame_load;
	logic resume;
	logic pause;
	logic frame_done;
	scb_frame_u frame;
	logic [CHAN_W-1:0] frame_bits;
	logic [READING_W-1:0] shifted_in;

	assign cnt_nxt = cnt + 1'b1;
	assign last_rep = (rep == REP_W'(ADC_REPEATS - 1));
	assign mex = mex_bit | mex_conv;

	// chan_idx is held by the controller for the whole channel
	always_comb begin
		if (mex_strobe) begin
			frame.mux.opcode = OP_ADC_MUX;
			frame.mux.code = chan_mux_code(chan_idx);
			frame.mux.pad = '0;
		end else begin
			frame.adc.opcode = OP_ADC_SPI;
			frame.adc.cfg = chan_adc_cfg(chan_idx);
		end
	end

	assign frame_bits = mex_strobe ? MUX_FRAME_BITS : ADC_FRAME_BITS;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			cnt <= '0;
			rep <= '0;
			mcs_n <= 1'b1;
			mex_strobe <= 1'b0;
			mex_conv <= 1'b0;
			frame_load <= 1'b0;
			resume <= 1'b0;
			chan_done <= 1'b0;
		end else begin
			frame_load <= 1'b0;
			resume <= 1'b0;
			chan_done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (chan_start) begin
						mex_strobe <= 1'b1;
						frame_load <= 1'b1;
						mcs_n <= 1'b0;
						state <= S_MUX;
					end
				end
				S_MUX: begin
					if (frame_done) begin
						mcs_n <= 1'b1;
						mex_strobe <= 1'b0;
						cnt <= '0;
						state <= S_SETTLE;
					end
				end
				S_SETTLE: begin
					cnt <= cnt_nxt;
					if (cnt == CNT_W'(MUX_SETTLE_CYCLES - 1)) begin
						rep <= '0;
						frame_load <= 1'b1;
						mcs_n <= 1'b0;
						state <= S_ADC;
					end
				end
				S_ADC: begin
					if (pause && !resume) begin // pause still high while resume is seen
						cnt <= '0;
						state <= S_CONV;
					end else if (frame_done) begin
						mcs_n <= 1'b1;
						if (last_rep) begin
							chan_done <= 1'b1;
							state <= S_IDLE;
						end else begin
							rep <= rep + 1'b1;
							state <= S_RELOAD;
						end
					end
				end
				S_CONV: begin
					cnt <= cnt_nxt;
					mex_conv <= (cnt_nxt >= CNT_W'(CONV_LOW)) &&
						(cnt_nxt < CNT_W'(CONV_LOW + CONV_PULSE_CYCLES));
					if (cnt == CNT_W'(CONV_LEN - 1)) begin
						mex_conv <= 1'b0;
						resume <= 1'b1;
						state <= S_ADC;
					end
				end
				S_RELOAD: begin
					frame_load <= 1'b1;
					mcs_n <= 1'b0;
					state <= S_ADC;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_ADC && frame_done && last_rep)
			chan_reading <= shifted_in; // last repeat wins
	end

	scb_serial_shifter u_shifter (
		.clk(clk),
		.rst(rst),
		.frame_load(frame_load),
		.frame(frame),
		.frame_bits(frame_bits),
		.mex_strobe(mex_strobe),
		.resume(resume),
		.mdo(mdo),
		.mdi(mdi),
		.msk(msk),
		.mex_bit(mex_bit),
		.pause(pause),
		.frame_done(frame_done),
		.shifted_in(shifted_in)
	);

endmodule

// File: logic/scb_monitor_ctrl.sv
//------------------------------
// monitor command handling
// channel scan, reading bank, finish flag
//------------------------------
`timescale 1ns/10ps

module scb_monitor_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic command_monitor,
	input  logic chan_done,
	input  logic [scb_pkg::READING_W-1:0] chan_reading,
	output logic chan_start,
	output logic [scb_pkg::CHAN_W-1:0] chan_idx,
	output logic monitor_finish,
	output logic [scb_pkg::CHANNELS-1:0][scb_pkg::READING_W-1:0] readings
);
	import scb_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_SCAN = 2'd1;
	localparam logic [1:0] S_FINISH = 2'd2;

	logic [1:0] state;
	logic cmd_q; // previous command level
	logic last_chan;

	assign last_chan = (chan_idx == CHAN_W'(CHANNELS - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			cmd_q <= 1'b0;
			chan_start <= 1'b0;
			chan_idx <= '0;
			monitor_finish <= 1'b0;
			readings <= '0;
		end else begin
			cmd_q <= command_monitor;
			chan_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (command_monitor && !cmd_q) begin // rising edge only
						chan_idx <= '0;
						chan_start <= 1'b1;
						state <= S_SCAN;
					end
				end
				S_SCAN: begin
					if (chan_done) begin
						readings[chan_idx] <= chan_reading;
						if (last_chan) begin
							state <= S_FINISH;
						end else begin
							chan_idx <= chan_idx + 1'b1;
							chan_start <= 1'b1;
						end
					end
				end
				S_FINISH: begin
					monitor_finish <= command_monitor;
					if (!command_monitor)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: logic/scb_tp_trigger.sv
//------------------------------
// test pulse trigger, one pulse per command rise
//------------------------------
`timescale 1ns/10ps

module scb_tp_trigger (
	input  logic clk,
	input  logic rst,
	input  logic command_tp_trig,
	output logic tp_trig
);

	localparam logic [1:0] S_ARMED = 2'd0;
	localparam logic [1:0] S_PULSE = 2'd1;
	localparam logic [1:0] S_WAIT = 2'd2; // wait for command release

	logic [1:0] state;

	assign tp_trig = (state == S_PULSE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= S_ARMED;
		else begin
			case (state)
				S_ARMED: if (command_tp_trig) state <= S_PULSE;
				S_PULSE: state <= S_WAIT;
				S_WAIT: if (!command_tp_trig) state <= S_ARMED;
				default: state <= S_ARMED;
			endcase
		end
	end

endmodule

// File: logic/scb_top.sv
//------------------------------
// slow control board top level
// monitor scan controller, adc sequencer, tp trigger
//------------------------------
`timescale 1ns/10ps

module scb_top #(
	parameter int MUX_SETTLE_CYCLES = 130000,
	parameter int CONV_PULSE_CYCLES = 230,
	parameter int ADC_REPEATS = 3
) (
	input  logic clk,
	input  logic rst,
	input  logic command_monitor,
	input  logic command_tp_trig,
	input  logic mdo,
	output logic mcs_n,
	output logic mdi,
	output logic msk,
	output logic mex,
	output logic tp_trig,
	output logic monitor_finish,
	output logic [scb_pkg::CHANNELS-1:0][scb_pkg::READING_W-1:0] readings
);
	import scb_pkg::*;

	logic chan_start;
	logic chan_done;
	logic [CHAN_W-1:0] chan_idx;
	logic [READING_W-1:0] chan_reading;

	//------------------------------
	scb_monitor_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.command_monitor(command_monitor),
		.chan_done(chan_done),
		.chan_reading(chan_reading),
		.chan_start(chan_start),
		.chan_idx(chan_idx),
		.monitor_finish(monitor_finish),
		.readings(readings)
	);

	scb_adc_sequencer #(
		.MUX_SETTLE_CYCLES(MUX_SETTLE_CYCLES),
		.CONV_PULSE_CYCLES(CONV_PULSE_CYCLES),
		.ADC_REPEATS(ADC_REPEATS)
	) u_seq (
		.clk(clk),
		.rst(rst),
		.chan_start(chan_start),
		.chan_idx(chan_idx),
		.mdo(mdo),
		.chan_done(chan_done),
		.chan_reading(chan_reading),
		.mcs_n(mcs_n),
		.mdi(mdi),
		.msk(msk),
		.mex(mex)
	);

	//------------------------------
	scb_tp_trigger u_tp (
		.clk(clk),
		.rst(rst),
		.command_tp_trig(command_tp_trig),
		.tp_trig(tp_trig)
	);

endmodule

// File: verif/scb_chk.sv
//------------------------------
// protocol assertions on scb_top
//------------------------------
`timescale 1ns/10ps

module scb_chk (
	input  logic clk,
	input  logic rst,
	input  logic mcs_n,
	input  logic msk,
	input  logic mex,
	input  logic tp_trig,
	input  logic command_monitor,
	input  logic monitor_finish
);

	int fail_count = 0;

	msk_in_frame: assert property (@(posedge clk) disable iff (rst) msk |-> !mcs_n)
		else begin
			fail_count++;
			$error("msk high while mcs_n is high");
		end

	mex_in_frame: assert property (@(posedge clk) disable iff (rst) mex |-> !mcs_n)
		else begin
			fail_count++;
			$error("mex high while mcs_n is high");
		end

	tp_single: assert property (@(posedge clk) disable iff (rst) tp_trig |=> !tp_trig)
		else begin
			fail_count++;
			$error("tp_trig high for two cycles in a row");
		end

	// finish drops one cycle after the command
	finish_with_cmd: assert property (@(posedge clk) disable iff (rst)
		monitor_finish |-> $past(command_monitor))
		else begin
			fail_count++;
			$error("monitor_finish high without command_monitor");
		end

endmodule

bind scb_top scb_chk u_chk (
	.clk(clk),
	.rst(rst),
	.mcs_n(mcs_n),
	.msk(msk),
	.mex(mex),
	.tp_trig(tp_trig),
	.command_monitor(command_monitor),
	.monitor_finish(monitor_finish)
);

// File: verif/scb_adc_model.sv
//------------------------------
// behavioral mux and adc model
// frame decode from mdi and msk, readout on mdo
//------------------------------
`timescale 1ns/10ps

module scb_adc_model #(
	parameter int ADC_REPEATS = 3
) (
	input  logic mcs_n,
	input  logic msk,
	input  logic mdi,
	input  logic mex,
	output logic mdo,
	output int mux_count,
	output logic [scb_pkg::OPCODE_W-1:0] mux_opcode,
	output logic [scb_pkg::MUX_W-1:0] mux_code
);
	import scb_pkg::*;

	logic [READING_W-1:0] words [0:255][0:ADC_REPEATS-1]; // one word per mux code and repeat
	logic [ADC_FRAME_BITS-1:0] bits_in = '0;
	int nbits = 0; // msk rises in this frame
	int nfall = 0; // msk falls in this frame
	int rep = 0;
	logic [MUX_W-1:0] cur_code = '0;
	logic [READING_W-1:0] conv_word = '0;
	logic [OPCODE_W-1:0] lead_op;
	scb_frame_u frame;

	initial begin
		mux_count = 0;
		mux_opcode = '0;
		mux_code = '0;
	end

	assign lead_op = OPCODE_W'(bits_in >> (nbits - int'(CONV_AFTER_BIT)));

	// word goes out MSB first from the fourth bit on
	assign mdo = (!mcs_n && lead_op == OP_ADC_SPI && nfall >= int'(CONV_AFTER_BIT) &&
		nfall < int'(ADC_FRAME_BITS)) ? conv_word[int'(ADC_FRAME_BITS) - 1 - nfall] : 1'b0;

	always @(posedge msk or negedge mcs_n) begin
		if (msk) begin
			nbits = nbits + 1;
			bits_in = {bits_in[ADC_FRAME_BITS-2:0], mdi};
		end else begin
			nbits = 0; // new frame
			bits_in = '0;
		end
	end

	always @(negedge msk or posedge mcs_n) begin
		if (mcs_n)
			nfall = 0;
		else
			nfall = nfall + 1;
	end

	//------------------------------
	always @(posedge mcs_n) begin
		if (nbits == int'(MUX_FRAME_BITS)) begin
			frame = scb_frame_u'(bits_in << (ADC_FRAME_BITS - MUX_FRAME_BITS));
			cur_code = frame.mux.code;
			rep = 0;
			mux_opcode = frame.mux.opcode;
			mux_code = frame.mux.code;
			mux_count = mux_count + 1;
		end else if (nbits == int'(ADC_FRAME_BITS)) begin
			rep = rep + 1;
		end
	end

	// end of conversion pulse
	always @(negedge mex) begin
		if (!mcs_n && nbits == int'(CONV_AFTER_BIT) && bits_in[OPCODE_W-1:0] == OP_ADC_SPI &&
			rep < ADC_REPEATS)
			conv_word = words[cur_code][rep];
	end

endmodule

// File: verif/tb_scb.sv
//------------------------------
// testbench for scb_top
// directed scan and trigger tests with adc model
//------------------------------
`timescale 1ns/10ps

module tb_scb;
	import scb_pkg::*;

	localparam int SETTLE = 40;
	localparam int CONV = 12;
	localparam int REPEATS = 3;
	localparam int BIT_CYCLES = 4;
	// conversion window is the pulse plus two gaps of 10
	localparam int CHAN_CYCLES = BIT_CYCLES * int'(MUX_FRAME_BITS) + SETTLE +
		REPEATS * (BIT_CYCLES * int'(ADC_FRAME_BITS) + CONV + 20 + 4) + 8;
	localparam int LIMIT = 2 * (3 * CHANNELS * CHAN_CYCLES + 400);

	logic clk;
	logic rst;
	logic command_monitor;
	logic command_tp_trig;
	logic mdo;
	logic mcs_n;
	logic mdi;
	logic msk;
	logic mex;
	logic tp_trig;
	logic monitor_finish;
	logic [CHANNELS-1:0][READING_W-1:0] readings;

	logic [31:0] lfsr;
	logic [READING_W-1:0] word_tab [0:255][0:REPEATS-1];
	logic [READING_W-1:0] expect_r [0:CHANNELS-1];
	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	int mux_count;
	int mux_checked = 0;
	logic [OPCODE_W-1:0] mux_opcode;
	logic [MUX_W-1:0] mux_code;
	logic [MUX_W-1:0] exp_code;

	scb_top #(
		.MUX_SETTLE_CYCLES(SETTLE),
		.CONV_PULSE_CYCLES(CONV),
		.ADC_REPEATS(REPEATS)
	) UUT (
		.clk(clk),
		.rst(rst),
		.command_monitor(command_monitor),
		.command_tp_trig(command_tp_trig),
		.mdo(mdo),
		.mcs_n(mcs_n),
		.mdi(mdi),
		.msk(msk),
		.mex(mex),
		.tp_trig(tp_trig),
		.monitor_finish(monitor_finish),
		.readings(readings)
	);

	scb_adc_model #(
		.ADC_REPEATS(REPEATS)
	) adc_model (
		.mcs_n(mcs_n),
		.msk(msk),
		.mdi(mdi),
		.mex(mex),
		.mdo(mdo),
		.mux_count(mux_count),
		.mux_opcode(mux_opcode),
		.mux_code(mux_code)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run stopped after %0d cycles", cycles);
		$display("** FAIL **");
		$finish;
	end

	// mux frames in scan order
	always @(posedge clk) begin
		if (mux_count != mux_checked) begin
			exp_code = chan_mux_code(CHAN_W'(mux_checked % CHANNELS));
			if (mux_opcode !== OP_ADC_MUX || mux_code !== exp_code) begin
				$display("Fail mux_frames: frame %0d expected opcode %b code %h, got opcode %b code %h",
					mux_checked, OP_ADC_MUX, exp_code, mux_opcode, mux_code);
				value_errors++;
			end
			mux_checked++;
		end
	end

	//------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hD000_0001;
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic check_reading(input string name, input logic [READING_W-1:0] exp,
		input logic [READING_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic fill_words();
		logic [31:0] w;
		for (int c = 0; c < 256; c++) begin
			for (int r = 0; r < REPEATS; r++) begin
				take_bits(READING_W, w);
				word_tab[c][r] = w[READING_W-1:0];
				adc_model.words[c][r] = w[READING_W-1:0];
			end
		end
		for (int i = 0; i < CHANNELS; i++)
			expect_r[i] = word_tab[chan_mux_code(CHAN_W'(i))][REPEATS-1]; // last repeat
	endtask

	task automatic check_bank(input string name);
		for (int i = 0; i < CHANNELS; i++)
			check_reading($sformatf("%s ch%0d", name, i), expect_r[i], readings[i]);
	endtask

	//------------------------------
	task automatic test_reset();
		check_flag("reset_mcs_n", 1'b1, mcs_n);
		check_flag("reset_mdi", 1'b0, mdi);
		check_flag("reset_msk", 1'b0, msk);
		check_flag("reset_mex", 1'b0, mex);
		check_flag("reset_tp_trig", 1'b0, tp_trig);
		check_flag("reset_finish", 1'b0, monitor_finish);
		for (int i = 0; i < CHANNELS; i++)
			check_reading($sformatf("reset_readings ch%0d", i), '0, readings[i]);
	endtask

	task automatic run_scan(input string name);
		fill_words();
		command_monitor = 1'b1;
		step(1);
		while (!monitor_finish)
			step(1);
		check_bank(name);
	endtask

	task automatic test_finish_hold();
		logic held;
		held = 1'b1;
		repeat (25) begin
			step(1);
			if (!monitor_finish)
				held = 1'b0;
		end
		check_flag("finish_hold", 1'b1, held);
		command_monitor = 1'b0;
		step(1);
		check_flag("finish_drop", 1'b0, monitor_finish);
		step(3);
		check_flag("finish_low", 1'b0, monitor_finish);
		check_bank("readings_kept");
	endtask

	task automatic test_tp_trigger();
		logic seen;
		command_tp_trig = 1'b1; // held high
		step(1);
		check_flag("tp_held_rise", 1'b1, tp_trig);
		seen = 1'b0;
		repeat (10) begin
			step(1);
			seen = seen | tp_trig;
		end
		check_flag("tp_held_once", 1'b0, seen);
		command_tp_trig = 1'b0;
		step(2);
		command_tp_trig = 1'b1; // one cycle pulse
		step(1);
		command_tp_trig = 1'b0;
		check_flag("tp_short_rise", 1'b1, tp_trig);
		seen = 1'b0;
		repeat (6) begin
			step(1);
			seen = seen | tp_trig;
		end
		check_flag("tp_short_once", 1'b0, seen);
	endtask

	task automatic test_tp_during_scan();
		fill_words();
		command_monitor = 1'b1;
		step(200);
		command_tp_trig = 1'b1;
		step(1);
		check_flag("tp_in_scan", 1'b1, tp_trig);
		step(1);
		check_flag("tp_in_scan_once", 1'b0, tp_trig);
		command_tp_trig = 1'b0;
		while (!monitor_finish)
			step(1);
		check_bank("scan_3");
		command_monitor = 1'b0;
		step(2);
	endtask

	//------------------------------
	initial begin
		rst = 1'b1;
		command_monitor = 1'b0;
		command_tp_trig = 1'b0;
		lfsr = 32'h1017;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		step(1);
		test_reset();
		run_scan("scan_1");
		test_finish_hold();
		run_scan("scan_2"); // new words replace the bank
		command_monitor = 1'b0;
		step(2);
		test_tp_trigger();
		test_tp_during_scan();
		if (mux_checked != 3 * CHANNELS) begin
			$display("model decoded %0d mux frames instead of %0d", mux_checked, 3 * CHANNELS);
			other_errors++;
		end
		other_errors += UUT.u_chk.fail_count;
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: verilog.f
logic/scb_pkg.sv
logic/scb_serial_shifter.sv
logic/scb_adc_sequencer.sv
logic/scb_monitor_ctrl.sv
logic/scb_tp_trigger.sv
logic/scb_top.sv
verif/scb_chk.sv
verif/scb_adc_model.sv
verif/tb_scb.sv

// File: Makefile
# Verilator build and run for the slow control board monitor testbench

VERILATOR ?= verilator
TOP ?= tb_scb
FLIST ?= verilog.f
BUILD ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= ** PASS **

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
SIM := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD)
